/* Bender.yml */
package:
  name: xt_peripherals

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/xt_bus_pkg.sv
      - rtl/xt_map_pkg.sv
      - rtl/xt_io_decode.sv
      - rtl/ems_page_mapper.sv
      - rtl/io_readback.sv
      - rtl/stage_sync.sv
      - rtl/xt_peripherals.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_xt_peripherals.sv

/* dv/tb_xt_peripherals.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the XT peripheral glue
// Decode, EMS mapper, printer latch, read-back priority
// and keyboard synchronizers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "xt_defines.svh"

module tb_xt_peripherals;

    logic                    clock;
    logic                    reset;
    xt_bus_pkg::xt_bus_t     bus_i;
    logic                    ems_enabled_i;
    xt_map_pkg::ems_window_t ems_window_i;
    logic [7:0]              pic_data_i;
    logic [7:0]              pit_data_i;
    logic [7:0]              ppi_data_i;
    logic [7:0]              kbd_code_i;
    logic                    kbd_irq_i;
    xt_bus_pkg::xt_cs_t      cs_o;
    xt_map_pkg::ems_bank_t   ems_bank_o;
    logic [7:0]              data_o;
    logic                    data_valid_o;
    logic [7:0]              kbd_code_o;
    logic                    kbd_irq_o;

    // Reference state of the page registers and the printer latch
    xt_map_pkg::ems_page_t ems_model [4];
    logic [7:0]            lpt_model;
    logic [31:0]           seed;
    string                 test_name;
    int                    errors;
    int                    errors_at_start;
    int                    tests_run;
    int                    tests_failed;

    xt_peripherals xt_peripherals_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Keyboard outputs trail their inputs by two system clocks
    assert property (@(posedge clock) disable iff (reset)
        {kbd_irq_o, kbd_code_o} == $past({kbd_irq_i, kbd_code_i}, 2))
    else begin
        $display("ERROR %s kbd: expected %h, actual %h", test_name,
                 $past({kbd_irq_i, kbd_code_i}, 2), $sampled({kbd_irq_o, kbd_code_o}));
        errors++;
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic xt_bus_pkg::xt_bus_t io_cycle(logic [19:0] addr, logic [7:0] data,
                                                     logic rd, logic wr);
        xt_bus_pkg::xt_bus_t b;
        b            = '1;
        b.address    = addr;
        b.data       = data;
        b.io_read_n  = !rd;
        b.io_write_n = !wr;
        b.aen_n      = 1'b0;
        return b;
    endfunction

    // Mostly near the decoded ports so that every select gets hit
    function automatic logic [19:0] pick_address(logic [31:0] r);
        case (r[31:30])
            2'd0:    return {12'h000, r[7:0]};
            2'd1:    return 20'(`XT_EMS_PORT) + 20'(r[2:0]);
            2'd2:    return 20'(`XT_LPT_PORT) + 20'(r[3:0]);
            default: return r[19:0];
        endcase
    endfunction

    function automatic xt_bus_pkg::xt_cs_t expected_cs(xt_bus_pkg::xt_bus_t b, logic ems_on);
        xt_bus_pkg::xt_cs_t cs;
        logic               cpu_io;
        logic               low;
        cpu_io      = (!b.io_read_n || !b.io_write_n) && !b.aen_n;
        low         = cpu_io && (b.address[9:8] == 2'b00);
        cs          = '0;
        cs.dma      = low && (b.address[7:5] == 3'd0);
        cs.pic      = low && (b.address[7:5] == 3'd1);
        cs.pit      = low && (b.address[7:5] == 3'd2);
        cs.ppi      = low && (b.address[7:5] == 3'd3);
        cs.dma_page = low && (b.address[7:5] == 3'd4);
        cs.ems      = cpu_io && ems_on && (b.address[15:2] == (`XT_EMS_PORT >> 2));
        cs.lpt      = cpu_io && (b.address[15:3] == (`XT_LPT_PORT >> 3));
        return cs;
    endfunction

    task automatic check(string what, logic [7:0] expected, logic [7:0] actual);
        assert (expected === actual) else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Drive one bus cycle and check all outputs before the model takes its write
    task automatic apply(xt_bus_pkg::xt_bus_t b, logic ems_on, logic [1:0] window);
        xt_bus_pkg::xt_cs_t    cs;
        xt_map_pkg::ems_page_t entry;
        logic [31:0]           r;
        logic [7:0]            data;
        logic                  valid;
        logic [3:0]            nibble;
        logic [3:0]            bank;
        r = next_rand();
        @(posedge clock);
        bus_i         <= b;
        ems_enabled_i <= ems_on;
        ems_window_i  <= window;
        pic_data_i    <= r[7:0];
        pit_data_i    <= r[15:8];
        ppi_data_i    <= r[23:16];
        @(negedge clock);
        cs    = expected_cs(b, ems_on);
        entry = ems_model[b.address[1:0]];
        valid = 1'b1;
        data  = 8'h00;
        if (!b.inta_n || (cs.pic && !b.io_read_n)) begin
            data = r[7:0];
        end else if (cs.pit && !b.io_read_n) begin
            data = r[15:8];
        end else if (cs.ppi && !b.io_read_n) begin
            data = r[23:16];
        end else if (cs.ems && !b.io_read_n) begin
            data = entry.enable ? {1'b0, entry.page} : 8'hFF;
        end else if (cs.lpt && !b.io_read_n) begin
            data = lpt_model;
        end else begin
            valid = 1'b0;
        end
        nibble = (window == 2'd0) ? `XT_EMS_BASE_A :
                 (window == 2'd1) ? `XT_EMS_BASE_C : `XT_EMS_BASE_D;
        for (int n = 0; n < 4; n++) begin
            bank[n] = b.io_read_n && b.io_write_n && ems_model[n].enable
                      && (b.address[19:16] == nibble) && (b.address[15:14] == 2'(n));
        end
        check("cs", {1'b0, cs}, {1'b0, cs_o});
        check("data", data, data_o);
        check("valid", {7'h00, valid}, {7'h00, data_valid_o});
        check("bank", {4'h0, bank}, {4'h0, ems_bank_o});
        if (cs.ems && !b.io_write_n) begin
            if (b.data == `XT_EMS_ERASE) begin
                ems_model[b.address[1:0]] = {1'b0, 7'h7F};
            end else if (b.data < `XT_EMS_MAP_LIMIT) begin
                ems_model[b.address[1:0]] = {1'b1, b.data[6:0]};
            end
        end
        if (cs.lpt && !b.io_write_n) begin
            lpt_model = b.data;
        end
    endtask

    task automatic start_test(string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("test %-10s %s", test_name, (errors == errors_at_start) ? "ok" : "FAILED");
    endtask

    // Whole run limit
    initial begin
        #200us;
        $display("Timeout: simulation did not reach the end of the test sequence");
        $display("Test failures found");
        $finish;
    end

    initial begin
        xt_bus_pkg::xt_bus_t b;
        logic [31:0]         r;
        logic [31:0]         s;
        logic [19:0]         addr;
        seed          = 32'hd194;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_name     = "reset";
        reset         = 1'b1;
        bus_i         = io_cycle(20'h0, 8'h00, 1'b0, 1'b0);
        ems_enabled_i = 1'b0;
        ems_window_i  = 2'd0;
        pic_data_i    = 8'h00;
        pit_data_i    = 8'h00;
        ppi_data_i    = 8'h00;
        kbd_code_i    = 8'h00;
        kbd_irq_i     = 1'b0;
        lpt_model     = 8'hFF;
        for (int i = 0; i < 4; i++) begin
            ems_model[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // First read of the latch still sees its reset value
        start_test("printer");
        apply(io_cycle(20'h378, 8'h00, 1'b1, 1'b0), 1'b0, 2'd0);
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            addr = 20'(`XT_LPT_PORT) + 20'(r[2:0]);
            apply(io_cycle(addr, r[15:8], 1'b0, 1'b1), 1'b0, 2'd0);
            apply(io_cycle(addr, 8'h00, 1'b1, 1'b0), 1'b0, 2'd0);
            apply(io_cycle({12'h000, 1'b0, 2'(r[17:16] % 3 + 1), r[20:16]},
                           8'h00, 1'b1, 1'b0), 1'b0, 2'd0);
        end
        finish_test();

        start_test("ems_regs");
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            addr = 20'(`XT_EMS_PORT) + 20'(r[1:0]);
            case (r[9:8])
                2'd0:    s = 32'hFF;
                2'd1:    s = {25'h0, r[22:16]};
                default: s = {24'h0, 1'b1, r[22:16]};
            endcase
            // Writes with EMS switched off must leave the register alone
            apply(io_cycle(addr, s[7:0], 1'b0, 1'b1), r[10] | r[11], 2'd0);
            apply(io_cycle(addr, 8'h00, 1'b1, 1'b0), 1'b1, 2'd0);
        end
        finish_test();

        // Half of the register writes disable their page
        start_test("ems_banks");
        for (int i = 0; i < 96; i++) begin
            r = next_rand();
            s = next_rand();
            if (r[0]) begin
                apply(io_cycle(20'(`XT_EMS_PORT) + 20'(r[2:1]),
                               r[3] ? `XT_EMS_ERASE : {1'b0, s[6:0]}, 1'b0, 1'b1),
                      1'b1, 2'd0);
            end else begin
                b = io_cycle({r[5] ? r[9:6] : 4'hA + 4'(r[7:6]), s[15:0]}, 8'h00, 1'b0, 1'b0);
                b.mem_read_n = 1'b0;
                apply(b, 1'b1, r[11:10]);
            end
        end
        finish_test();

        start_test("priority");
        for (int i = 0; i < 96; i++) begin
            r = next_rand();
            s = next_rand();
            b = io_cycle(pick_address(r), 8'h00, s[0], 1'b0);
            b.inta_n = s[1];
            apply(b, s[2], 2'd0);
        end
        finish_test();

        start_test("decode");
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            s = next_rand();
            b = io_cycle(pick_address(r), s[7:0], s[8], s[9]);
            b.aen_n      = s[10] & s[11];
            b.inta_n     = s[12] | s[13];
            b.mem_read_n = s[14];
            apply(b, s[15], s[17:16]);
        end
        finish_test();

        start_test("keyboard");
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            @(posedge clock);
            kbd_code_i <= r[7:0];
            kbd_irq_i  <= r[8];
        end
        // The last code is compared on the third edge and reported before the negedge
        repeat (3) @(posedge clock);
        @(negedge clock);
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* rtl/ems_page_mapper.sv */
//////////////////////////////////////////////////////////////////////
// EMS page mapper with four page registers
// Register read value and frame bank match outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "xt_defines.svh"

module ems_page_mapper (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_bus_pkg::xt_bus_t     bus_i,
    input  logic                    ems_sel_i,
    input  xt_map_pkg::ems_window_t window_i,
    output logic [7:0]              read_data_o,
    output xt_map_pkg::ems_bank_t   bank_o
);

    xt_map_pkg::ems_page_t pages [4];
    xt_map_pkg::ems_page_t selected;
    logic [1:0]            index;
    logic [3:0]            frame;
    logic                  mem_cycle;

    assign index = bus_i.address[1:0];

    // Page register writes
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                pages[i] <= '0;
            end
        end else if (ems_sel_i && !bus_i.io_write_n) begin
            if (bus_i.data == `XT_EMS_ERASE) begin
                pages[index].enable <= 1'b0;
                pages[index].page   <= 7'h7F;
            end else if (bus_i.data < `XT_EMS_MAP_LIMIT) begin
                pages[index].enable <= 1'b1;
                pages[index].page   <= bus_i.data[6:0];
            end
            // 80h..FEh are ignored
        end
    end

    // Disabled pages read back as the erase code
    assign selected    = pages[index];
    assign read_data_o = selected.enable ? {1'b0, selected.page} : `XT_EMS_ERASE;

    // Frame segment nibble
    always_comb begin
        case (window_i)
            2'd0:    frame = `XT_EMS_BASE_A;
            2'd1:    frame = `XT_EMS_BASE_C;
            default: frame = `XT_EMS_BASE_D;
        endcase
    end

    assign mem_cycle = bus_i.io_read_n & bus_i.io_write_n;

    // Bank n covers frame + n * 16 KB
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            bank_o[n] = mem_cycle && pages[n].enable
                        && (bus_i.address[19:14] == {frame, 2'(n)});
        end
    end

endmodule

/* rtl/io_readback.sv */
//////////////////////////////////////////////////////////////////////
// Printer data latch and CPU read data multiplexer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module io_readback (
    input  logic                clock,
    input  logic                reset,
    input  xt_bus_pkg::xt_bus_t bus_i,
    input  xt_bus_pkg::xt_cs_t  cs_i,
    input  logic [7:0]          pic_data_i,
    input  logic [7:0]          pit_data_i,
    input  logic [7:0]          ppi_data_i,
    input  logic [7:0]          ems_data_i,
    output logic [7:0]          data_o,
    output logic                data_valid_o
);

    logic [7:0] lpt_data;
    logic       io_read;

    // Printer port holds all ones until written
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
        end else if (cs_i.lpt && !bus_i.io_write_n) begin
            lpt_data <= bus_i.data;
        end
    end

    assign io_read = ~bus_i.io_read_n;

    // Fixed priority, interrupt vector first
    always_comb begin
        data_valid_o = 1'b1;
        data_o       = 8'h00;
        if (!bus_i.inta_n) begin
            data_o = pic_data_i;
        end else if (cs_i.pic && io_read) begin
            data_o = pic_data_i;
        end else if (cs_i.pit && io_read) begin
            data_o = pit_data_i;
        end else if (cs_i.ppi && io_read) begin
            data_o = ppi_data_i;
        end else if (cs_i.ems && io_read) begin
            data_o = ems_data_i;
        end else if (cs_i.lpt && io_read) begin
            data_o = lpt_data;
        end else begin
            // Nothing of ours on the bus
            data_valid_o = 1'b0;
        end
    end

endmodule

/* rtl/stage_sync.sv */
//////////////////////////////////////////////////////////////////////
// Flop chain synchronizer for any packed payload
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "xt_defines.svh"

module stage_sync #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t chain [`XT_SYNC_STAGES];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `XT_SYNC_STAGES; i++) begin
                chain[i] <= '0;
            end
        end else begin
            chain[0] <= d_i;
            for (int i = 1; i < `XT_SYNC_STAGES; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign q_o = chain[`XT_SYNC_STAGES-1];

endmodule

/* rtl/xt_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// CPU bus cycle type and peripheral chip select type
//////////////////////////////////////////////////////////////////////

package xt_bus_pkg;

    // One CPU bus cycle as the chipset sees it, strobes active low
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  data;
        logic        io_read_n;
        logic        io_write_n;
        logic        mem_read_n;
        logic        mem_write_n;
        // Low while the CPU owns the bus
        logic        aen_n;
        // Interrupt acknowledge cycle
        logic        inta_n;
    } xt_bus_t;

    // Active high peripheral selects
    typedef struct packed {
        // 8237 at 000h
        logic dma;
        // 8259 at 020h
        logic pic;
        // 8253 at 040h
        logic pit;
        // 8255 at 060h
        logic ppi;
        // Page register at 080h
        logic dma_page;
        logic ems;
        logic lpt;
    } xt_cs_t;

endpackage

/* rtl/xt_defines.svh */
//////////////////////////////////////////////////////////////////////
// Address map constants of the XT chipset glue
// EMS page register and frame settings, synchronizer depth
//////////////////////////////////////////////////////////////////////

`ifndef XT_DEFINES_SVH
`define XT_DEFINES_SVH

// I/O port bases

// Four EMS page registers at 260h..263h
`define XT_EMS_PORT 16'h0260

// Printer data latch at 378h..37Fh
`define XT_LPT_PORT 16'h0378

// EMS frame segments, top address nibble

// Frame at A0000h
`define XT_EMS_BASE_A 4'hA

// Frame at C0000h
`define XT_EMS_BASE_C 4'hC

// Frame at D0000h
`define XT_EMS_BASE_D 4'hD

// EMS page register data codes

// Writing this code disables the page
`define XT_EMS_ERASE 8'hFF

// Values below this limit load a page number
`define XT_EMS_MAP_LIMIT 8'h80

// Keyboard crossing

// Flops in each synchronizer chain
`define XT_SYNC_STAGES 2

`endif

/* rtl/xt_io_decode.sv */
//////////////////////////////////////////////////////////////////////
// I/O address decoder of the XT chipset
// Selects for DMA, PIC, PIT, PPI, DMA page, EMS and printer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "xt_defines.svh"

module xt_io_decode (
    input  xt_bus_pkg::xt_bus_t bus_i,
    input  logic                ems_enabled_i,
    output xt_bus_pkg::xt_cs_t  cs_o
);

    localparam logic [15:0] EMS_PORT = `XT_EMS_PORT;
    localparam logic [15:0] LPT_PORT = `XT_LPT_PORT;

    logic       io_request;
    logic       io_cpu;
    logic       low_page;
    logic [2:0] block;

    // Any I/O strobe while the CPU drives the address
    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cpu     = io_request & ~bus_i.aen_n;

    // Motherboard devices live in the first 100h ports, 20h each
    assign low_page = io_cpu & ~bus_i.address[9] & ~bus_i.address[8];
    assign block    = bus_i.address[7:5];

    always_comb begin
        cs_o          = '0;
        cs_o.dma      = low_page && (block == 3'd0);
        cs_o.pic      = low_page && (block == 3'd1);
        cs_o.pit      = low_page && (block == 3'd2);
        cs_o.ppi      = low_page && (block == 3'd3);
        cs_o.dma_page = low_page && (block == 3'd4);

        // 260h..263h, only while EMS is switched on
        cs_o.ems = io_cpu && ems_enabled_i
                   && (bus_i.address[15:2] == EMS_PORT[15:2]);

        // 378h..37Fh
        cs_o.lpt = io_cpu && (bus_i.address[15:3] == LPT_PORT[15:3]);
    end

endmodule

/* rtl/xt_map_pkg.sv */
//////////////////////////////////////////////////////////////////////
// EMS page register, frame window and bank match types
//////////////////////////////////////////////////////////////////////

package xt_map_pkg;

    // One EMS page register
    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_page_t;

    // Frame choice: 0 for A, 1 for C, D otherwise
    typedef logic [1:0] ems_window_t;

    // One match bit per 16 KB bank of the frame
    typedef logic [3:0] ems_bank_t;

endpackage

/* rtl/xt_peripherals.sv */
//////////////////////////////////////////////////////////////////////
// XT peripheral bus glue top level
// Decoder, EMS mapper, read-back and keyboard synchronizers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module xt_peripherals (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_bus_pkg::xt_bus_t     bus_i,
    input  logic                    ems_enabled_i,
    input  xt_map_pkg::ems_window_t ems_window_i,
    input  logic [7:0]              pic_data_i,
    input  logic [7:0]              pit_data_i,
    input  logic [7:0]              ppi_data_i,
    input  logic [7:0]              kbd_code_i,
    input  logic                    kbd_irq_i,
    output xt_bus_pkg::xt_cs_t      cs_o,
    output xt_map_pkg::ems_bank_t   ems_bank_o,
    output logic [7:0]              data_o,
    output logic                    data_valid_o,
    output logic [7:0]              kbd_code_o,
    output logic                    kbd_irq_o
);

    xt_bus_pkg::xt_cs_t cs;
    logic [7:0]         ems_data;

    xt_io_decode xt_io_decode_i (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .cs_o          (cs)
    );

    assign cs_o = cs;

    ems_page_mapper ems_page_mapper_i (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_i),
        .ems_sel_i   (cs.ems),
        .window_i    (ems_window_i),
        .read_data_o (ems_data),
        .bank_o      (ems_bank_o)
    );

    io_readback io_readback_i (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .cs_i         (cs),
        .pic_data_i   (pic_data_i),
        .pit_data_i   (pit_data_i),
        .ppi_data_i   (ppi_data_i),
        .ems_data_i   (ems_data),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

    // Keyboard controller signals into the system clock
    stage_sync #(.payload_t(logic [7:0])) kbd_code_sync_i (
        .clock (clock),
        .reset (reset),
        .d_i   (kbd_code_i),
        .q_o   (kbd_code_o)
    );

    stage_sync #(.payload_t(logic)) kbd_irq_sync_i (
        .clock (clock),
        .reset (reset),
        .d_i   (kbd_irq_i),
        .q_o   (kbd_irq_o)
    );

endmodule

/* sim.f */
+incdir+rtl
rtl/xt_bus_pkg.sv
rtl/xt_map_pkg.sv
rtl/xt_io_decode.sv
rtl/ems_page_mapper.sv
rtl/io_readback.sv
rtl/stage_sync.sv
rtl/xt_peripherals.sv
dv/tb_xt_peripherals.sv
